/* design/rv_decode_pkg.sv */
package rv_decode_pkg;

    localparam int XLEN      = 32;
    localparam int RF_ADDR_W = 5;

    typedef logic [XLEN-1:0]      inst_t;
    typedef logic [RF_ADDR_W-1:0] rf_addr_t;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [3:0] {
        CLS_OP, CLS_OP_IMM, CLS_LOAD, CLS_STORE, CLS_BRANCH,
        CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_JALR, CLS_ILLEGAL
    } inst_class_e;

    typedef enum logic [4:0] {
        ALU_OP_NOP, ALU_OP_ADD, ALU_OP_SUB, ALU_OP_SLL, ALU_OP_SLT, ALU_OP_SLTU,
        ALU_OP_XOR, ALU_OP_SRL, ALU_OP_SRA, ALU_OP_OR, ALU_OP_AND,
        // branch compares
        ALU_OP_EQ, ALU_OP_NE, ALU_OP_LT, ALU_OP_GE, ALU_OP_LTU, ALU_OP_GEU
    } alu_op_e;

    typedef enum logic [2:0] {
        ALU_NO_SRC, ALU_RS_RS, ALU_RS_IMM, ALU_ZERO_IMM, ALU_PC_IMM, ALU_PC_4
    } alu_src_e;

    typedef enum logic [1:0] {
        BJU_NO_SRC, BJU_PC_IMM, BJU_RS_IMM
    } bju_src_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_kind_e;

    localparam logic [6:0] FUNCT7_BASE   = 7'h00;
    localparam logic [6:0] FUNCT7_ALT    = 7'h20;
    localparam logic [6:0] FUNCT7_MULDIV = 7'h01;

    // OP / OP_IMM
    localparam logic [2:0] F3_ADD_SUB = 3'd0;
    localparam logic [2:0] F3_SLL     = 3'd1;
    localparam logic [2:0] F3_SLT     = 3'd2;
    localparam logic [2:0] F3_SLTU    = 3'd3;
    localparam logic [2:0] F3_XOR     = 3'd4;
    localparam logic [2:0] F3_SRL_SRA = 3'd5;
    localparam logic [2:0] F3_OR      = 3'd6;
    localparam logic [2:0] F3_AND     = 3'd7;

    // M extension, funct7 = 0x01
    localparam logic [2:0] F3_MUL    = 3'd0;
    localparam logic [2:0] F3_MULH   = 3'd1;
    localparam logic [2:0] F3_MULHSU = 3'd2;
    localparam logic [2:0] F3_MULHU  = 3'd3;
    localparam logic [2:0] F3_DIV    = 3'd4;
    localparam logic [2:0] F3_DIVU   = 3'd5;
    localparam logic [2:0] F3_REM    = 3'd6;
    localparam logic [2:0] F3_REMU   = 3'd7;

    localparam logic [2:0] F3_BEQ  = 3'd0;
    localparam logic [2:0] F3_BNE  = 3'd1;
    localparam logic [2:0] F3_BLT  = 3'd4;
    localparam logic [2:0] F3_BGE  = 3'd5;
    localparam logic [2:0] F3_BLTU = 3'd6;
    localparam logic [2:0] F3_BGEU = 3'd7;

    localparam logic [2:0] F3_JALR = 3'd0;

    localparam logic [2:0] F3_LB  = 3'd0;
    localparam logic [2:0] F3_LH  = 3'd1;
    localparam logic [2:0] F3_LW  = 3'd2;
    localparam logic [2:0] F3_LBU = 3'd4;
    localparam logic [2:0] F3_LHU = 3'd5;

    localparam logic [2:0] F3_SB = 3'd0;
    localparam logic [2:0] F3_SH = 3'd1;
    localparam logic [2:0] F3_SW = 3'd2;

    // top bit is the sign, low nibble the byte lanes
    localparam logic [4:0] LMASK_B  = 5'b10001;
    localparam logic [4:0] LMASK_H  = 5'b10011;
    localparam logic [4:0] LMASK_W  = 5'b11111;
    localparam logic [4:0] LMASK_BU = 5'b00001;
    localparam logic [4:0] LMASK_HU = 5'b00011;

    localparam logic [3:0] SMASK_B = 4'b0001;
    localparam logic [3:0] SMASK_H = 4'b0011;
    localparam logic [3:0] SMASK_W = 4'b1111;

    // multiplier operand signedness, rs1 then rs2
    localparam logic [1:0] SEXT_SIGNED_SIGNED     = 2'b11;
    localparam logic [1:0] SEXT_SIGNED_UNSIGNED   = 2'b10;
    localparam logic [1:0] SEXT_UNSIGNED_UNSIGNED = 2'b00;

    localparam logic WORD_LOW      = 1'b0;
    localparam logic WORD_HIGH     = 1'b1;
    localparam logic DIV_QUOTIENT  = 1'b0;
    localparam logic DIV_REMAINDER = 1'b1;

    typedef struct packed {
        logic       is_mul;
        logic       is_div;
        logic [1:0] sign_extend;
        logic       word_sel;
        logic       div_sign;
        logic       div_res_sel;
    } muldiv_ctrl_t;

    typedef struct packed {
        logic       req_mem;
        logic       is_load;
        logic [4:0] l_mask;
        logic       is_store;
        logic [3:0] s_mask;
    } mem_ctrl_t;

    typedef struct packed {
        alu_op_e  alu_op;
        alu_src_e alu_src;
        logic     is_bj;
        bju_src_e bju_src;
    } alu_ctrl_t;

    typedef struct packed {
        alu_ctrl_t    alu;
        muldiv_ctrl_t muldiv;
        mem_ctrl_t    mem;
        logic         req_rf;
        logic         illegal;
    } decode_ctrl_t;

    localparam alu_ctrl_t ALU_DEFAULT = '{
        alu_op:  ALU_OP_NOP,
        alu_src: ALU_NO_SRC,
        is_bj:   1'b0,
        bju_src: BJU_NO_SRC
    };

    localparam muldiv_ctrl_t MULDIV_DEFAULT = '{
        is_mul:      1'b0,
        is_div:      1'b0,
        sign_extend: SEXT_SIGNED_SIGNED,
        word_sel:    WORD_LOW,
        div_sign:    1'b1,
        div_res_sel: DIV_QUOTIENT
    };

    localparam mem_ctrl_t MEM_DEFAULT = '0;

    localparam decode_ctrl_t CTRL_DEFAULT = '{
        alu:     ALU_DEFAULT,
        muldiv:  MULDIV_DEFAULT,
        mem:     MEM_DEFAULT,
        req_rf:  1'b0,
        illegal: 1'b0
    };

endpackage

/* design/opcode_ctrl.sv */
module opcode_ctrl
    import rv_decode_pkg::*;
(
    input  opcode_e     opcode_i,
    input  logic        alu_illegal_i,
    input  logic        mem_illegal_i,
    output inst_class_e class_o,
    output imm_kind_e   imm_kind_o,
    output logic        req_rf_o,
    output logic        illegal_o
);

    imm_kind_e imm_kind_raw;
    logic      req_rf_raw;

    // opcode classification, no funct fields looked at here
    always_comb begin
        class_o      = CLS_ILLEGAL;
        imm_kind_raw = IMM_NONE;
        req_rf_raw   = 1'b0;
        case (opcode_i)
            OPC_OP: begin
                class_o    = CLS_OP;
                req_rf_raw = 1'b1;
            end
            OPC_OP_IMM: begin
                class_o      = CLS_OP_IMM;
                imm_kind_raw = IMM_I;
                req_rf_raw   = 1'b1;
            end
            OPC_LOAD: begin
                class_o      = CLS_LOAD;
                imm_kind_raw = IMM_I;
                req_rf_raw   = 1'b1;
            end
            OPC_STORE: begin
                class_o      = CLS_STORE;
                imm_kind_raw = IMM_S;
            end
            OPC_BRANCH: begin
                class_o      = CLS_BRANCH;
                imm_kind_raw = IMM_B;
            end
            OPC_LUI: begin
                class_o      = CLS_LUI;
                imm_kind_raw = IMM_U;
                req_rf_raw   = 1'b1;
            end
            OPC_AUIPC: begin
                class_o      = CLS_AUIPC;
                imm_kind_raw = IMM_U;
                req_rf_raw   = 1'b1;
            end
            OPC_JAL: begin
                class_o      = CLS_JAL;
                imm_kind_raw = IMM_J;
                req_rf_raw   = 1'b1;
            end
            OPC_JALR: begin
                class_o      = CLS_JALR;
                imm_kind_raw = IMM_I;
                req_rf_raw   = 1'b1;
            end
            // SYSTEM, MISC-MEM and anything unknown
            default: ;
        endcase
    end

    // merge opcode verdict with the datapath funct checks
    always_comb begin
        illegal_o  = (class_o == CLS_ILLEGAL) | alu_illegal_i | mem_illegal_i;
        imm_kind_o = illegal_o ? IMM_NONE : imm_kind_raw;
        req_rf_o   = req_rf_raw & ~illegal_o;
    end

endmodule

/* design/alu_op_decode.sv */
module alu_op_decode
    import rv_decode_pkg::*;
(
    input  inst_class_e  class_i,
    input  logic [2:0]   funct3_i,
    input  logic [6:0]   funct7_i,
    output alu_ctrl_t    alu_o,
    output muldiv_ctrl_t muldiv_o,
    output logic         funct_illegal_o
);

    // shared funct3 row of OP and OP_IMM, shifts are right logical here
    function automatic alu_op_e base_op(input logic [2:0] f3);
        alu_op_e op;
        case (f3)
            F3_ADD_SUB: op = ALU_OP_ADD;
            F3_SLL:     op = ALU_OP_SLL;
            F3_SLT:     op = ALU_OP_SLT;
            F3_SLTU:    op = ALU_OP_SLTU;
            F3_XOR:     op = ALU_OP_XOR;
            F3_SRL_SRA: op = ALU_OP_SRL;
            F3_OR:      op = ALU_OP_OR;
            default:    op = ALU_OP_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        alu_o           = ALU_DEFAULT;
        muldiv_o        = MULDIV_DEFAULT;
        funct_illegal_o = 1'b0;
        case (class_i)
            CLS_OP: begin
                alu_o.alu_src = ALU_RS_RS;
                case (funct7_i)
                    FUNCT7_BASE: alu_o.alu_op = base_op(funct3_i);
                    FUNCT7_ALT: begin
                        if (funct3_i == F3_ADD_SUB) begin
                            alu_o.alu_op = ALU_OP_SUB;
                        end else if (funct3_i == F3_SRL_SRA) begin
                            alu_o.alu_op = ALU_OP_SRA;
                        end else begin
                            funct_illegal_o = 1'b1;
                        end
                    end
                    FUNCT7_MULDIV: begin
                        // mul/div unit takes the operands, ALU idles
                        alu_o.alu_src = ALU_NO_SRC;
                        muldiv_o.is_mul = ~funct3_i[2];
                        muldiv_o.is_div = funct3_i[2];
                        case (funct3_i)
                            F3_MUL:    muldiv_o.sign_extend = SEXT_UNSIGNED_UNSIGNED;
                            F3_MULH:   muldiv_o.word_sel = WORD_HIGH;
                            F3_MULHSU: begin
                                muldiv_o.sign_extend = SEXT_SIGNED_UNSIGNED;
                                muldiv_o.word_sel    = WORD_HIGH;
                            end
                            F3_MULHU: begin
                                muldiv_o.sign_extend = SEXT_UNSIGNED_UNSIGNED;
                                muldiv_o.word_sel    = WORD_HIGH;
                            end
                            F3_DIV:  muldiv_o.div_sign = 1'b1;
                            F3_DIVU: muldiv_o.div_sign = 1'b0;
                            F3_REM:  muldiv_o.div_res_sel = DIV_REMAINDER;
                            default: begin
                                muldiv_o.div_sign    = 1'b0;
                                muldiv_o.div_res_sel = DIV_REMAINDER;
                            end
                        endcase
                    end
                    default: funct_illegal_o = 1'b1;
                endcase
            end
            CLS_OP_IMM: begin
                alu_o.alu_src = ALU_RS_IMM;
                alu_o.alu_op  = base_op(funct3_i);
                if (funct3_i == F3_SLL) begin
                    funct_illegal_o = (funct7_i != FUNCT7_BASE);
                end else if (funct3_i == F3_SRL_SRA) begin
                    if (funct7_i == FUNCT7_ALT) begin
                        alu_o.alu_op = ALU_OP_SRA;
                    end else if (funct7_i != FUNCT7_BASE) begin
                        funct_illegal_o = 1'b1;
                    end
                end
            end
            CLS_BRANCH: begin
                alu_o.alu_src = ALU_RS_RS;
                alu_o.is_bj   = 1'b1;
                alu_o.bju_src = BJU_PC_IMM;
                case (funct3_i)
                    F3_BEQ:  alu_o.alu_op = ALU_OP_EQ;
                    F3_BNE:  alu_o.alu_op = ALU_OP_NE;
                    F3_BLT:  alu_o.alu_op = ALU_OP_LT;
                    F3_BGE:  alu_o.alu_op = ALU_OP_GE;
                    F3_BLTU: alu_o.alu_op = ALU_OP_LTU;
                    F3_BGEU: alu_o.alu_op = ALU_OP_GEU;
                    default: funct_illegal_o = 1'b1;
                endcase
            end
            CLS_LUI: begin
                alu_o.alu_op  = ALU_OP_ADD;
                alu_o.alu_src = ALU_ZERO_IMM;
            end
            CLS_AUIPC: begin
                alu_o.alu_op  = ALU_OP_ADD;
                alu_o.alu_src = ALU_PC_IMM;
            end
            CLS_JAL, CLS_JALR: begin
                // link value pc + 4 goes through the ALU
                alu_o.alu_op  = ALU_OP_ADD;
                alu_o.alu_src = ALU_PC_4;
                alu_o.is_bj   = 1'b1;
                alu_o.bju_src = (class_i == CLS_JAL) ? BJU_PC_IMM : BJU_RS_IMM;
                // jalr only defines funct3 = 0
                funct_illegal_o = (class_i == CLS_JALR) && (funct3_i != F3_JALR);
            end
            default: ;
        endcase
    end

endmodule

/* design/mem_op_decode.sv */
module mem_op_decode
    import rv_decode_pkg::*;
(
    input  inst_class_e class_i,
    input  logic [2:0]  funct3_i,
    output mem_ctrl_t   mem_o,
    output logic        funct_illegal_o
);

    always_comb begin
        mem_o           = MEM_DEFAULT;
        funct_illegal_o = 1'b0;
        case (class_i)
            CLS_LOAD: begin
                mem_o.req_mem = 1'b1;
                mem_o.is_load = 1'b1;
                case (funct3_i)
                    F3_LB:   mem_o.l_mask = LMASK_B;
                    F3_LH:   mem_o.l_mask = LMASK_H;
                    F3_LW:   mem_o.l_mask = LMASK_W;
                    F3_LBU:  mem_o.l_mask = LMASK_BU;
                    F3_LHU:  mem_o.l_mask = LMASK_HU;
                    default: funct_illegal_o = 1'b1;
                endcase
            end
            CLS_STORE: begin
                mem_o.req_mem  = 1'b1;
                mem_o.is_store = 1'b1;
                case (funct3_i)
                    F3_SB:   mem_o.s_mask = SMASK_B;
                    F3_SH:   mem_o.s_mask = SMASK_H;
                    F3_SW:   mem_o.s_mask = SMASK_W;
                    default: funct_illegal_o = 1'b1;
                endcase
            end
            default: ;
        endcase
        // no half-built request on a bad width
        if (funct_illegal_o) begin
            mem_o = MEM_DEFAULT;
        end
    end

endmodule

/* design/imm_gen.sv */
module imm_gen
    import rv_decode_pkg::*;
(
    input  inst_t           inst_i,
    input  imm_kind_e       imm_kind_i,
    output logic [XLEN-1:0] imm_o
);

    logic sign;

    assign sign = inst_i[31];

    always_comb begin
        case (imm_kind_i)
            IMM_I: imm_o = {{20{sign}}, inst_i[31:20]};
            IMM_S: imm_o = {{20{sign}}, inst_i[31:25], inst_i[11:7]};
            // branch offset in halfwords
            IMM_B: begin
                imm_o = {{19{sign}}, sign, inst_i[7], inst_i[30:25],
                         inst_i[11:8], 1'b0};
            end
            IMM_U: imm_o = {inst_i[31:12], 12'b0};
            IMM_J: begin
                imm_o = {{11{sign}}, sign, inst_i[19:12], inst_i[20],
                         inst_i[30:21], 1'b0};
            end
            default: imm_o = '0;
        endcase
    end

endmodule

/* design/decode_stage.sv */
module decode_stage
    import rv_decode_pkg::*;
(
    input  logic            clk,
    input  logic            rst_i,
    input  logic            inst_valid_i,
    input  inst_t           inst_i,
    output logic            valid_o,
    output inst_t           inst_o,
    output rf_addr_t        rs1_o,
    output rf_addr_t        rs2_o,
    output rf_addr_t        rd_o,
    output logic [XLEN-1:0] imm_o,
    output decode_ctrl_t    ctrl_o
);

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    inst_class_e     inst_class;
    imm_kind_e       imm_kind;
    alu_ctrl_t       alu_ctrl;
    muldiv_ctrl_t    muldiv_ctrl;
    mem_ctrl_t       mem_ctrl;
    logic            alu_illegal;
    logic            mem_illegal;
    logic            req_rf;
    logic            illegal;
    logic [XLEN-1:0] imm;
    decode_ctrl_t    ctrl_d;

    assign opcode = opcode_e'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    opcode_ctrl u_opcode_ctrl (
        .opcode_i      (opcode),
        .alu_illegal_i (alu_illegal),
        .mem_illegal_i (mem_illegal),
        .class_o       (inst_class),
        .imm_kind_o    (imm_kind),
        .req_rf_o      (req_rf),
        .illegal_o     (illegal)
    );

    alu_op_decode u_alu_op_decode (
        .class_i         (inst_class),
        .funct3_i        (funct3),
        .funct7_i        (funct7),
        .alu_o           (alu_ctrl),
        .muldiv_o        (muldiv_ctrl),
        .funct_illegal_o (alu_illegal)
    );

    mem_op_decode u_mem_op_decode (
        .class_i         (inst_class),
        .funct3_i        (funct3),
        .mem_o           (mem_ctrl),
        .funct_illegal_o (mem_illegal)
    );

    imm_gen u_imm_gen (
        .inst_i     (inst_i),
        .imm_kind_i (imm_kind),
        .imm_o      (imm)
    );

    // illegal decode collapses to the default word
    always_comb begin
        if (illegal) begin
            ctrl_d         = CTRL_DEFAULT;
            ctrl_d.illegal = 1'b1;
        end else begin
            ctrl_d.alu     = alu_ctrl;
            ctrl_d.muldiv  = muldiv_ctrl;
            ctrl_d.mem     = mem_ctrl;
            ctrl_d.req_rf  = req_rf;
            ctrl_d.illegal = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
            ctrl_o  <= CTRL_DEFAULT;
        end else begin
            valid_o <= inst_valid_i;
            if (inst_valid_i) begin
                ctrl_o <= ctrl_d;
            end
        end
    end

    // payload holds while no instruction arrives
    always_ff @(posedge clk) begin
        if (inst_valid_i) begin
            inst_o <= inst_i;
            rs1_o  <= inst_i[19:15];
            rs2_o  <= inst_i[24:20];
            rd_o   <= inst_i[11:7];
            imm_o  <= imm;
        end
    end

endmodule

/* tb/decode_stage_chk.sv */
module decode_stage_chk
    import rv_decode_pkg::*;
(
    input logic            clk,
    input logic            rst_i,
    input logic            inst_valid_i,
    input inst_t           inst_i,
    input logic            valid_o,
    input inst_t           inst_o,
    input rf_addr_t        rs1_o,
    input rf_addr_t        rs2_o,
    input rf_addr_t        rd_o,
    input logic [XLEN-1:0] imm_o,
    input decode_ctrl_t    ctrl_o
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned  fail_count = 0;
    logic         exp_valid;
    logic         have_inst;
    logic         check_en;
    inst_t        exp_inst;
    logic [6:0]   opc;
    logic         legal;
    decode_ctrl_t ill_word;

    // legality straight from the RV32IM encoding tables
    function automatic logic is_legal(input inst_t i);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = i[14:12];
        f7 = i[31:25];
        case (i[6:0])
            OPC_OP: begin
                return (f7 == FUNCT7_BASE) || (f7 == FUNCT7_MULDIV) ||
                       (f7 == FUNCT7_ALT && (f3 == 3'd0 || f3 == 3'd5));
            end
            OPC_OP_IMM: begin
                if (f3 == 3'd1) begin
                    return f7 == FUNCT7_BASE;
                end
                if (f3 == 3'd5) begin
                    return f7 == FUNCT7_BASE || f7 == FUNCT7_ALT;
                end
                return 1'b1;
            end
            OPC_LOAD:   return f3 != 3'd3 && f3 < 3'd6;
            OPC_STORE:  return f3 < 3'd3;
            OPC_BRANCH: return f3 != 3'd2 && f3 != 3'd3;
            OPC_JALR:   return f3 == 3'd0;
            OPC_LUI, OPC_AUIPC, OPC_JAL: return 1'b1;
            default:    return 1'b0;
        endcase
    endfunction

    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    return alt ? ALU_OP_SUB : ALU_OP_ADD;
            3'd1:    return ALU_OP_SLL;
            3'd2:    return ALU_OP_SLT;
            3'd3:    return ALU_OP_SLTU;
            3'd4:    return ALU_OP_XOR;
            3'd5:    return alt ? ALU_OP_SRA : ALU_OP_SRL;
            3'd6:    return ALU_OP_OR;
            default: return ALU_OP_AND;
        endcase
    endfunction

    function automatic alu_op_e branch_op(input logic [2:0] f3);
        case (f3)
            3'd0:    return ALU_OP_EQ;
            3'd1:    return ALU_OP_NE;
            3'd4:    return ALU_OP_LT;
            3'd5:    return ALU_OP_GE;
            3'd6:    return ALU_OP_LTU;
            default: return ALU_OP_GEU;
        endcase
    endfunction

    function automatic alu_ctrl_t exp_alu(input inst_t i);
        alu_ctrl_t  a;
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = i[14:12];
        f7 = i[31:25];
        a = '{alu_op: ALU_OP_NOP, alu_src: ALU_NO_SRC, is_bj: 1'b0, bju_src: BJU_NO_SRC};
        case (i[6:0])
            OPC_OP: begin
                if (f7 != FUNCT7_MULDIV) begin
                    a.alu_op  = arith_op(f3, f7 == FUNCT7_ALT);
                    a.alu_src = ALU_RS_RS;
                end
            end
            OPC_OP_IMM: begin
                // only the right shift row reads funct7
                a.alu_op  = arith_op(f3, f3 == 3'd5 && f7 == FUNCT7_ALT);
                a.alu_src = ALU_RS_IMM;
            end
            OPC_BRANCH: begin
                a.alu_op  = branch_op(f3);
                a.alu_src = ALU_RS_RS;
                a.is_bj   = 1'b1;
                a.bju_src = BJU_PC_IMM;
            end
            OPC_LUI: begin
                a.alu_op  = ALU_OP_ADD;
                a.alu_src = ALU_ZERO_IMM;
            end
            OPC_AUIPC: begin
                a.alu_op  = ALU_OP_ADD;
                a.alu_src = ALU_PC_IMM;
            end
            OPC_JAL, OPC_JALR: begin
                a.alu_op  = ALU_OP_ADD;
                a.alu_src = ALU_PC_4;
                a.is_bj   = 1'b1;
                a.bju_src = (i[6:0] == OPC_JAL) ? BJU_PC_IMM : BJU_RS_IMM;
            end
            default: ;
        endcase
        return a;
    endfunction

    function automatic muldiv_ctrl_t exp_muldiv(input inst_t i);
        muldiv_ctrl_t m;
        logic [2:0]   f3;
        f3 = i[14:12];
        // idle word has signed operands and a signed quotient
        m = '{is_mul: 1'b0, is_div: 1'b0, sign_extend: 2'b11, word_sel: 1'b0,
              div_sign: 1'b1, div_res_sel: 1'b0};
        if (i[6:0] == OPC_OP && i[31:25] == FUNCT7_MULDIV) begin
            m.is_mul = !f3[2];
            m.is_div = f3[2];
            if (!f3[2]) begin
                m.word_sel = (f3 != 3'd0);
                if (f3 == 3'd0 || f3 == 3'd3) begin
                    m.sign_extend = 2'b00;
                end
                if (f3 == 3'd2) begin
                    m.sign_extend = 2'b10;
                end
            end else begin
                m.div_sign    = !f3[0];
                m.div_res_sel = f3[1];
            end
        end
        return m;
    endfunction

    function automatic mem_ctrl_t exp_mem(input inst_t i);
        mem_ctrl_t  m;
        logic [3:0] lanes;
        lanes = (i[13:12] == 2'd0) ? 4'b0001 : (i[13:12] == 2'd1) ? 4'b0011 : 4'b1111;
        m = '0;
        if (i[6:0] == OPC_LOAD) begin
            m.req_mem = 1'b1;
            m.is_load = 1'b1;
            m.l_mask  = {!i[14], lanes};
        end else if (i[6:0] == OPC_STORE) begin
            m.req_mem  = 1'b1;
            m.is_store = 1'b1;
            m.s_mask   = lanes;
        end
        return m;
    endfunction

    function automatic logic [XLEN-1:0] exp_imm(input inst_t i);
        case (i[6:0])
            OPC_OP_IMM, OPC_LOAD, OPC_JALR: return 32'($signed(i[31:20]));
            OPC_STORE:  return 32'($signed({i[31:25], i[11:7]}));
            OPC_BRANCH: return 32'($signed({i[31], i[7], i[30:25], i[11:8], 1'b0}));
            OPC_LUI, OPC_AUIPC: return {i[31:12], 12'h000};
            OPC_JAL:    return 32'($signed({i[31], i[19:12], i[20], i[30:21], 1'b0}));
            default:    return '0;
        endcase
    endfunction

    assign opc      = exp_inst[6:0];
    assign legal    = is_legal(exp_inst);
    assign check_en = !rst_i && have_inst;

    always_comb begin
        ill_word         = CTRL_DEFAULT;
        ill_word.illegal = 1'b1;
    end

    // one cycle of latency and the payload held between valid beats
    always_ff @(posedge clk) begin
        if (rst_i) begin
            exp_valid <= 1'b0;
            have_inst <= 1'b0;
        end else begin
            exp_valid <= inst_valid_i;
            if (inst_valid_i) begin
                have_inst <= 1'b1;
                exp_inst  <= inst_i;
            end
        end
    end

    a_reset: assert property (@(posedge clk) rst_i |=> !valid_o && ctrl_o == CTRL_DEFAULT)
        else begin
            fail_count++;
            $error("CHECK FAILED valid_o/ctrl_o after reset got %h %h exp 0 %h",
                   $sampled(valid_o), $sampled(ctrl_o), CTRL_DEFAULT);
        end

    a_valid: assert property (@(posedge clk) !rst_i |-> valid_o == exp_valid)
        else begin
            fail_count++;
            $error("CHECK FAILED valid_o got %h exp %h", $sampled(valid_o), $sampled(exp_valid));
        end

    a_fields: assert property (@(posedge clk) check_en |->
            inst_o == exp_inst && rs1_o == exp_inst[19:15] &&
            rs2_o == exp_inst[24:20] && rd_o == exp_inst[11:7])
        else begin
            fail_count++;
            $error("CHECK FAILED inst_o/rs1_o/rs2_o/rd_o got %h %h %h %h exp inst %h",
                   $sampled(inst_o), $sampled(rs1_o), $sampled(rs2_o), $sampled(rd_o),
                   $sampled(exp_inst));
        end

    // ctrl_o and imm_o keep the last decode through idle cycles
    a_illegal: assert property (@(posedge clk) check_en && !legal |->
            ctrl_o == ill_word && imm_o == '0)
        else begin
            fail_count++;
            $error("CHECK FAILED ctrl_o/imm_o got %h %h exp %h 0",
                   $sampled(ctrl_o), $sampled(imm_o), $sampled(ill_word));
        end

    a_alu: assert property (@(posedge clk) check_en && legal |->
            ctrl_o.alu == exp_alu(exp_inst))
        else begin
            fail_count++;
            $error("CHECK FAILED ctrl_o.alu got %h exp %h",
                   $sampled(ctrl_o.alu), exp_alu($sampled(exp_inst)));
        end

    a_muldiv: assert property (@(posedge clk) check_en && legal |->
            ctrl_o.muldiv == exp_muldiv(exp_inst))
        else begin
            fail_count++;
            $error("CHECK FAILED ctrl_o.muldiv got %h exp %h",
                   $sampled(ctrl_o.muldiv), exp_muldiv($sampled(exp_inst)));
        end

    a_mem: assert property (@(posedge clk) check_en && legal |->
            ctrl_o.mem == exp_mem(exp_inst))
        else begin
            fail_count++;
            $error("CHECK FAILED ctrl_o.mem got %h exp %h",
                   $sampled(ctrl_o.mem), exp_mem($sampled(exp_inst)));
        end

    // stores and branches write no register
    a_req_rf: assert property (@(posedge clk) check_en && legal |->
            {ctrl_o.req_rf, ctrl_o.illegal} == {!(opc == OPC_STORE || opc == OPC_BRANCH), 1'b0})
        else begin
            fail_count++;
            $error("CHECK FAILED ctrl_o.req_rf/illegal got %h %h for inst %h",
                   $sampled(ctrl_o.req_rf), $sampled(ctrl_o.illegal), $sampled(exp_inst));
        end

    a_imm: assert property (@(posedge clk) check_en && legal |-> imm_o == exp_imm(exp_inst))
        else begin
            fail_count++;
            $error("CHECK FAILED imm_o got %h exp %h",
                   $sampled(imm_o), exp_imm($sampled(exp_inst)));
        end

endmodule

bind decode_stage decode_stage_chk u_chk (
    .clk          (clk),
    .rst_i        (rst_i),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .valid_o      (valid_o),
    .inst_o       (inst_o),
    .rs1_o        (rs1_o),
    .rs2_o        (rs2_o),
    .rd_o         (rd_o),
    .imm_o        (imm_o),
    .ctrl_o       (ctrl_o)
);

/* tb/tb_decode_stage.sv */
module tb_decode_stage
    import rv_decode_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD          = 4;
    localparam int RST_CYCLES          = 8;
    localparam int N_DIRECTED          = 24;
    localparam int RANDOM_PER_DIRECTED = 16;
    localparam int N_TESTS             = N_DIRECTED * (1 + RANDOM_PER_DIRECTED);
    localparam int WATCHDOG_NS         = N_TESTS * CLK_PERIOD * 2 + RST_CYCLES * CLK_PERIOD
                                         + 10 * CLK_PERIOD;

    logic            clk = 1'b0;
    logic            rst_i;
    logic            inst_valid_i;
    inst_t           inst_i;
    logic            valid_o;
    inst_t           inst_o;
    rf_addr_t        rs1_o;
    rf_addr_t        rs2_o;
    rf_addr_t        rd_o;
    logic [XLEN-1:0] imm_o;
    decode_ctrl_t    ctrl_o;
    logic [31:0]     lfsr = 32'h51da;

    // hand-picked corners, legal and illegal
    inst_t directed [N_DIRECTED] = '{
        32'h003100b3, 32'h403100b3, 32'h403150b3, 32'h023100b3,
        32'h023120b3, 32'h023170b3, 32'h403110b3, 32'hfff10093,
        32'h40315093, 32'h40311093, 32'h00812083, 32'h00015083,
        32'h00013083, 32'hfe312e23, 32'h00313023, 32'h00208463,
        32'h0020a463, 32'h123450b7, 32'h12345097, 32'h010000ef,
        32'h004100e7, 32'h004110e7, 32'h00000073, 32'h0ff0000f
    };

    decode_stage dut0 (
        .clk          (clk),
        .rst_i        (rst_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .valid_o      (valid_o),
        .inst_o       (inst_o),
        .rs1_o        (rs1_o),
        .rs2_o        (rs2_o),
        .rd_o         (rd_o),
        .imm_o        (imm_o),
        .ctrl_o       (ctrl_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_failure(input string why);
        $display("Test failed");
        $fatal(1, "%s", why);
    endtask

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic inst_t random_inst();
        inst_t      w;
        logic [3:0] opc_sel;
        logic [1:0] f7_sel;
        w       = rand_bits(32);
        opc_sel = 4'(rand_bits(4));
        f7_sel  = 2'(rand_bits(2));
        case (opc_sel)
            4'd0:    w[6:0] = OPC_OP;
            4'd1:    w[6:0] = OPC_OP_IMM;
            4'd2:    w[6:0] = OPC_LOAD;
            4'd3:    w[6:0] = OPC_STORE;
            4'd4:    w[6:0] = OPC_BRANCH;
            4'd5:    w[6:0] = OPC_LUI;
            4'd6:    w[6:0] = OPC_AUIPC;
            4'd7:    w[6:0] = OPC_JAL;
            4'd8:    w[6:0] = OPC_JALR;
            // system and misc-mem
            4'd9:    w[6:0] = 7'b1110011;
            4'd10:   w[6:0] = 7'b0001111;
            default: ;
        endcase
        case (f7_sel)
            2'd0:    w[31:25] = FUNCT7_BASE;
            2'd1:    w[31:25] = FUNCT7_ALT;
            2'd2:    w[31:25] = FUNCT7_MULDIV;
            default: ;
        endcase
        return w;
    endfunction

    // one valid beat, sometimes followed by an idle cycle of junk
    task automatic send(input inst_t w);
        logic gap;
        inst_valid_i = 1'b1;
        inst_i       = w;
        @(posedge clk);
        #1;
        gap = lfsr_bit();
        if (gap) begin
            inst_valid_i = 1'b0;
            inst_i       = random_inst();
            @(posedge clk);
            #1;
        end
    endtask

    always @(negedge clk) begin
        if (dut0.u_chk.fail_count != 0) begin
            report_failure("an assertion in decode_stage_chk failed");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        report_failure("watchdog expired before the stimulus finished");
    end

    initial begin
        rst_i        = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_i = 1'b0;
        for (int d = 0; d < N_DIRECTED; d++) begin
            send(directed[d]);
            for (int r = 0; r < RANDOM_PER_DIRECTED; r++) begin
                send(random_inst());
            end
        end
        inst_valid_i = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        if (dut0.u_chk.fail_count != 0) begin
            report_failure("assertion failures at the end of the run");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

/* sim.f */
design/rv_decode_pkg.sv
design/opcode_ctrl.sv
design/alu_op_decode.sv
design/mem_op_decode.sv
design/imm_gen.sv
design/decode_stage.sv
tb/decode_stage_chk.sv
tb/tb_decode_stage.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_decode_stage
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
RUN_ARGS  ?= +verilator+error+limit+100

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) $(RUN_ARGS)

clean:
	rm -rf $(BUILD_DIR)
